// File: hdl/ctrl_pkg.sv
package ctrl_pkg;

    localparam int WORD_W      = 32;
    localparam int OPCODE_W    = 5;
    localparam int REG_ADDR_W  = 4;   // 16 registers in the bank
    localparam int STEP_W      = 3;
    localparam int OFFSET_W    = 19;
    localparam int VALUE_W     = 23;
    localparam int TARGET_W    = 27;
    localparam int ARITH_PAD_W = 15;

    // Encodings follow the existing processor, HALT is all ones
    typedef enum logic [OPCODE_W-1:0] {
        OP_NOP  = 5'b00000,
        OP_ADD  = 5'b00001,
        OP_SUB  = 5'b00010,
        OP_AND  = 5'b00011,
        OP_OR   = 5'b00100,
        OP_XOR  = 5'b00101,
        OP_SLL  = 5'b00110,  // Shift amount is an immediate
        OP_SRL  = 5'b00111,
        OP_OUT  = 5'b01000,
        OP_ADDI = 5'b01001,
        OP_ANDI = 5'b01010,
        OP_ORI  = 5'b01011,
        OP_LW   = 5'b01100,
        OP_SW   = 5'b01101,
        OP_J    = 5'b01110,
        OP_JEQ  = 5'b01111,
        OP_JNE  = 5'b10000,
        OP_JCA  = 5'b10001,
        OP_JNC  = 5'b10010,
        OP_SUBI = 5'b10011,
        OP_LIS  = 5'b10100,  // Sign extended from bit 22
        OP_LIU  = 5'b10101,
        OP_JZE  = 5'b10110,
        OP_JNZ  = 5'b10111,
        OP_NOT  = 5'b11000,
        OP_HALT = 5'b11111
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_NOT = 3'd7
    } alu_op_t;

    typedef logic [STEP_W-1:0]     step_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam reg_addr_t TEMP_REG        = 4'd1;  // Scratch for immediates
    localparam step_t     STEP_FETCH_ADDR = 3'd0;
    localparam step_t     STEP_FETCH_DATA = 3'd1;
    localparam step_t     STEP_EXEC       = 3'd2;

    // Register ALU format
    typedef struct packed {
        opcode_t                  opcode;
        reg_addr_t                rd;
        reg_addr_t                rs;
        reg_addr_t                rt;
        logic [ARITH_PAD_W-1:0]   unused;
    } arith_fmt_t;

    // Memory, compare branch and OUT format
    typedef struct packed {
        opcode_t                  opcode;
        reg_addr_t                rs;
        reg_addr_t                rt;
        logic [OFFSET_W-1:0]      offset;
    } mem_fmt_t;

    typedef struct packed {
        opcode_t                  opcode;
        logic [REG_ADDR_W-1:0]    spare;
        logic [VALUE_W-1:0]       value;
    } load_fmt_t;

    typedef struct packed {
        opcode_t                  opcode;
        logic [TARGET_W-1:0]      target;
    } far_fmt_t;

    typedef union packed {
        arith_fmt_t arith_view;
        mem_fmt_t   mem_view;
        load_fmt_t  load_view;
        far_fmt_t   far_view;
    } instr_word_t;

endpackage

// File: hdl/operand_decoder.sv
module operand_decoder
    import ctrl_pkg::*;
(
    input  instr_word_t       ir_word,
    output reg_addr_t         reg_a,
    output reg_addr_t         reg_b,
    output reg_addr_t         reg_d,
    output logic [WORD_W-1:0] imm_value
);

    opcode_t opcode;
    logic    mem_format;

    assign opcode = ir_word.arith_view.opcode;

    // J adds its base register from the top field, like the memory format
    always_comb begin
        case (opcode)
            OP_LW, OP_SW, OP_JEQ, OP_JNE, OP_OUT, OP_J: mem_format = 1'b1;
            default:                                    mem_format = 1'b0;
        endcase
    end

    always_comb begin
        if (mem_format) begin
            reg_a = ir_word.mem_view.rs;
            reg_b = ir_word.mem_view.rt;
        end else begin
            reg_a = ir_word.arith_view.rs;
            reg_b = ir_word.arith_view.rt;
        end
    end

    // Same bits in every format, only meaningful where a result is written
    assign reg_d = ir_word.arith_view.rd;

    always_comb begin
        case (opcode)
            OP_LIS: begin
                imm_value = {{(WORD_W-VALUE_W){ir_word.load_view.value[VALUE_W-1]}},
                             ir_word.load_view.value};
            end
            OP_J, OP_LIU: begin
                imm_value = {{(WORD_W-VALUE_W){1'b0}}, ir_word.load_view.value};
            end
            OP_JCA, OP_JNC, OP_JZE, OP_JNZ: begin
                imm_value = {{(WORD_W-TARGET_W){1'b0}}, ir_word.far_view.target};
            end
            default: begin
                imm_value = {{(WORD_W-OFFSET_W){1'b0}}, ir_word.mem_view.offset};
            end
        endcase
    end

endmodule

// File: hdl/control_sequencer.sv
module control_sequencer
    import ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  opcode_t   opcode,
    input  reg_addr_t reg_a,
    input  reg_addr_t reg_b,
    input  reg_addr_t reg_d,
    input  logic      zero_flag,
    input  logic      carry_flag,
    output logic      rb_load,
    output logic      rb_drive,
    output reg_addr_t rb_addr,
    output reg_addr_t alu_src_a,
    output reg_addr_t alu_src_b,
    output alu_op_t   alu_op,
    output logic      alu_load,
    output logic      flags_load,
    output logic      pc_increment,
    output logic      pc_load,
    output logic      pc_drive,
    output logic      mar_load,
    output logic      ram_load,
    output logic      ram_drive,
    output logic      ir_load,
    output logic      out_load,
    output logic      bus_drive
);

    step_t step;
    logic  running;     // Set on the first edge after reset release
    logic  last_step;   // Final step of the current opcode
    logic  hold_step;
    logic  in_exec;     // First execute step
    logic  in_exec_1;   // Second execute step
    logic  taken;

    function automatic alu_op_t alu_op_of(input opcode_t op);
        case (op)
            OP_SUB, OP_SUBI:  alu_op_of = ALU_SUB;
            OP_AND, OP_ANDI:  alu_op_of = ALU_AND;
            OP_OR, OP_ORI:    alu_op_of = ALU_OR;
            OP_XOR:           alu_op_of = ALU_XOR;
            OP_SLL:           alu_op_of = ALU_SLL;
            OP_SRL:           alu_op_of = ALU_SRL;
            OP_NOT:           alu_op_of = ALU_NOT;
            default:          alu_op_of = ALU_ADD;
        endcase
    endfunction

    assign in_exec   = (step == STEP_EXEC);
    assign in_exec_1 = (step == STEP_EXEC + 3'd1);

    // Branch rule per opcode
    always_comb begin
        case (opcode)
            OP_JEQ, OP_JZE: taken = zero_flag;
            OP_JNE, OP_JNZ: taken = !zero_flag;
            OP_JCA:         taken = carry_flag;
            OP_JNC:         taken = !carry_flag;
            default:        taken = 1'b0;
        endcase
    end

    // Step 0 shows up on the cycle after the first edge out of reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            step    <= STEP_FETCH_ADDR;
            running <= 1'b0;
        end else begin
            running <= 1'b1;
            if (running && !hold_step) begin
                if (last_step) begin
                    step <= STEP_FETCH_ADDR;
                end else begin
                    step <= step + 3'd1;  // NOP runs through and wraps
                end
            end
        end
    end

    always_comb begin
        rb_load      = 1'b0;
        rb_drive     = 1'b0;
        rb_addr      = '0;
        alu_src_a    = '0;
        alu_src_b    = '0;
        alu_op       = ALU_ADD;
        alu_load     = 1'b0;
        flags_load   = 1'b0;
        pc_increment = 1'b0;
        pc_load      = 1'b0;
        pc_drive     = 1'b0;
        mar_load     = 1'b0;
        ram_load     = 1'b0;
        ram_drive    = 1'b0;
        ir_load      = 1'b0;
        out_load     = 1'b0;
        bus_drive    = 1'b0;
        last_step    = 1'b0;
        hold_step    = 1'b0;

        if (running) begin
            case (step)
                STEP_FETCH_ADDR: begin
                    pc_drive = 1'b1;
                    mar_load = 1'b1;
                end
                STEP_FETCH_DATA: begin
                    ram_drive    = 1'b1;
                    ir_load      = 1'b1;
                    pc_increment = 1'b1;
                end
                default: begin
                    case (opcode)
                        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_NOT: begin
                            alu_src_a  = reg_a;
                            alu_src_b  = reg_b;
                            alu_op     = alu_op_of(opcode);
                            alu_load   = 1'b1;
                            rb_addr    = reg_d;
                            rb_load    = 1'b1;
                            flags_load = 1'b1;
                            last_step  = 1'b1;
                        end
                        OP_ADDI, OP_SUBI, OP_ANDI, OP_ORI, OP_SLL, OP_SRL: begin
                            if (in_exec) begin
                                bus_drive = 1'b1;       // Immediate into scratch
                                rb_addr   = TEMP_REG;
                                rb_load   = 1'b1;
                            end else begin
                                alu_src_a  = reg_a;
                                alu_src_b  = TEMP_REG;
                                alu_op     = alu_op_of(opcode);
                                alu_load   = 1'b1;
                                rb_addr    = reg_d;
                                rb_load    = 1'b1;
                                flags_load = 1'b1;
                                last_step  = 1'b1;
                            end
                        end
                        OP_LW, OP_SW: begin
                            if (in_exec) begin
                                bus_drive = 1'b1;       // Offset into scratch
                                rb_addr   = TEMP_REG;
                                rb_load   = 1'b1;
                            end else if (in_exec_1) begin
                                alu_src_a = reg_b;      // Base plus offset
                                alu_src_b = TEMP_REG;
                                alu_op    = ALU_ADD;
                                alu_load  = 1'b1;
                                mar_load  = 1'b1;
                            end else begin
                                rb_addr   = reg_a;
                                last_step = 1'b1;
                                if (opcode == OP_LW) begin
                                    ram_drive = 1'b1;
                                    rb_load   = 1'b1;
                                end else begin
                                    rb_drive = 1'b1;
                                    ram_load = 1'b1;
                                end
                            end
                        end
                        OP_J: begin
                            if (in_exec) begin
                                bus_drive = 1'b1;
                                rb_addr   = TEMP_REG;
                                rb_load   = 1'b1;
                            end else begin
                                alu_src_a = reg_a;
                                alu_src_b = TEMP_REG;
                                alu_op    = ALU_ADD;
                                alu_load  = 1'b1;
                                pc_load   = 1'b1;       // Target comes from the ALU
                                last_step = 1'b1;
                            end
                        end
                        OP_JEQ, OP_JNE: begin
                            if (in_exec) begin
                                // Compare only, the difference is not kept
                                alu_src_a  = reg_a;
                                alu_src_b  = reg_b;
                                alu_op     = ALU_SUB;
                                flags_load = 1'b1;
                            end else begin
                                bus_drive = taken;
                                pc_load   = taken;
                                last_step = 1'b1;
                            end
                        end
                        OP_JCA, OP_JNC, OP_JZE, OP_JNZ: begin
                            bus_drive = taken;
                            pc_load   = taken;
                            last_step = 1'b1;
                        end
                        OP_OUT: begin
                            rb_addr   = reg_a;
                            rb_drive  = 1'b1;
                            out_load  = 1'b1;
                            last_step = 1'b1;
                        end
                        OP_LIS, OP_LIU: begin
                            bus_drive = 1'b1;
                            rb_addr   = reg_d;
                            rb_load   = 1'b1;
                            last_step = 1'b1;
                        end
                        OP_HALT: hold_step = 1'b1;  // Stays here until reset
                        default: begin
                            // NOP and unused codes do nothing
                        end
                    endcase
                end
            endcase
        end
    end

endmodule

// File: hdl/instruction_decoder.sv
module instruction_decoder
    import ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  instr_word_t       ir_word,
    input  logic              zero_flag,
    input  logic              carry_flag,
    output logic              rb_load,
    output logic              rb_drive,
    output reg_addr_t         rb_addr,
    output reg_addr_t         alu_src_a,
    output reg_addr_t         alu_src_b,
    output alu_op_t           alu_op,
    output logic              alu_load,
    output logic              flags_load,
    output logic              pc_increment,
    output logic              pc_load,
    output logic              pc_drive,
    output logic              mar_load,
    output logic              ram_load,
    output logic              ram_drive,
    output logic              ir_load,
    output logic              out_load,
    output logic [WORD_W-1:0] bus_data,   // Valid only with bus_drive
    output logic              bus_drive
);

    reg_addr_t reg_a;
    reg_addr_t reg_b;
    reg_addr_t reg_d;

    operand_decoder operand_decoder_inst (
        .ir_word   (ir_word),
        .reg_a     (reg_a),
        .reg_b     (reg_b),
        .reg_d     (reg_d),
        .imm_value (bus_data)
    );

    control_sequencer control_sequencer_inst (
        .clk          (clk),
        .reset        (reset),
        .opcode       (ir_word.arith_view.opcode),  // Same position in every view
        .reg_a        (reg_a),
        .reg_b        (reg_b),
        .reg_d        (reg_d),
        .zero_flag    (zero_flag),
        .carry_flag   (carry_flag),
        .rb_load      (rb_load),
        .rb_drive     (rb_drive),
        .rb_addr      (rb_addr),
        .alu_src_a    (alu_src_a),
        .alu_src_b    (alu_src_b),
        .alu_op       (alu_op),
        .alu_load     (alu_load),
        .flags_load   (flags_load),
        .pc_increment (pc_increment),
        .pc_load      (pc_load),
        .pc_drive     (pc_drive),
        .mar_load     (mar_load),
        .ram_load     (ram_load),
        .ram_drive    (ram_drive),
        .ir_load      (ir_load),
        .out_load     (out_load),
        .bus_drive    (bus_drive)
    );

endmodule

// File: bench/decoder_props.sv
module decoder_props
    import ctrl_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input logic      rb_load,
    input logic      rb_drive,
    input reg_addr_t rb_addr,
    input reg_addr_t alu_src_b,
    input logic      alu_load,
    input logic      flags_load,
    input logic      pc_increment,
    input logic      pc_load,
    input logic      pc_drive,
    input logic      mar_load,
    input logic      ram_load,
    input logic      ram_drive,
    input logic      ir_load,
    input logic      out_load,
    input logic      bus_drive
);
    timeunit 1ns;
    timeprecision 100ps;

    logic any_strobe;

    assign any_strobe = rb_load | rb_drive | alu_load | flags_load | pc_increment
                      | pc_load | pc_drive | mar_load | ram_load | ram_drive
                      | ir_load | out_load | bus_drive;

    ram_one_way: assert property (@(posedge clk) disable iff (reset)
        !(ram_load && ram_drive))
        else $error("RAM loaded and driven in the same cycle");

    bus_one_owner: assert property (@(posedge clk) disable iff (reset)
        !(bus_drive && rb_drive))
        else $error("bus driven by decoder and register bank together");

    // Scratch register must hold the immediate before the ALU reads it
    temp_loaded_first: assert property (@(posedge clk) disable iff (reset)
        (alu_load && alu_src_b == TEMP_REG) |-> $past(rb_load && rb_addr == TEMP_REG))
        else $error("ALU read the scratch register before it was loaded");

    quiet_in_reset: assert property (@(posedge clk) reset |-> !any_strobe)
        else $error("control strobe active during reset");

endmodule

bind control_sequencer decoder_props decoder_props_inst (
    .clk          (clk),
    .reset        (reset),
    .rb_load      (rb_load),
    .rb_drive     (rb_drive),
    .rb_addr      (rb_addr),
    .alu_src_b    (alu_src_b),
    .alu_load     (alu_load),
    .flags_load   (flags_load),
    .pc_increment (pc_increment),
    .pc_load      (pc_load),
    .pc_drive     (pc_drive),
    .mar_load     (mar_load),
    .ram_load     (ram_load),
    .ram_drive    (ram_drive),
    .ir_load      (ir_load),
    .out_load     (out_load),
    .bus_drive    (bus_drive)
);

// File: bench/tb_instruction_decoder.sv
module tb_instruction_decoder
    import ctrl_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    logic              clk;
    logic              reset;
    instr_word_t       ir_word;
    logic              zero_flag;
    logic              carry_flag;
    logic              rb_load;
    logic              rb_drive;
    reg_addr_t         rb_addr;
    reg_addr_t         alu_src_a;
    reg_addr_t         alu_src_b;
    alu_op_t           alu_op;
    logic              alu_load;
    logic              flags_load;
    logic              pc_increment;
    logic              pc_load;
    logic              pc_drive;
    logic              mar_load;
    logic              ram_load;
    logic              ram_drive;
    logic              ir_load;
    logic              out_load;
    logic [WORD_W-1:0] bus_data;
    logic              bus_drive;

    instruction_decoder instruction_decoder_inst (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (exp !== got) begin
            $display("mismatch %s exp %h got %h", name, exp, got);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic give_up(input string what);
        $display("timeout after 20 cycles waiting for %s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    // Returns on the falling edge of a step 0 cycle
    task automatic wait_fetch(input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!pc_drive) begin
            cycles++;
            if (cycles > 20) give_up(what);
            @(negedge clk);
        end
        compare("mar_load", 1, 32'(mar_load));
    endtask

    // Step 1 reads the instruction from RAM
    task automatic check_fetch_data();
        compare("ram_drive", 1, 32'(ram_drive));
        compare("ir_load", 1, 32'(ir_load));
        compare("pc_increment", 1, 32'(pc_increment));
    endtask

    task automatic run_instruction(input logic [31:0] word, input logic z, input logic c,
                                   input int exp_len, input bit has_bus,
                                   input logic [31:0] exp_bus, input logic exp_taken,
                                   input logic [2:0] exp_alu, input logic [3:0] exp_rb);
        int        count;
        bit        done;
        bit        saw_bus;
        bit        saw_pc_load;
        logic [31:0] bus_seen;
        reg_addr_t bus_rb;
        alu_op_t   last_alu;
        reg_addr_t last_rb;
        reg_addr_t last_src_a;
        reg_addr_t last_src_b;
        logic [5:0] last_strobes;  // alu_load rb_load rb_drive ram_load ram_drive out_load
        logic      flags_exec;
        logic      mar_exec;
        opcode_t   op;
        op           = opcode_t'(word[31:27]);
        count        = 1;
        done         = 0;
        saw_bus      = 0;
        saw_pc_load  = 0;
        bus_seen     = '0;
        bus_rb       = '0;
        last_alu     = ALU_ADD;
        last_rb      = '0;
        last_src_a   = '0;
        last_src_b   = '0;
        last_strobes = '0;
        flags_exec   = 0;
        mar_exec     = 0;
        @(posedge clk);
        ir_word    <= word;   // Present for the ir_load cycle
        zero_flag  <= z;
        carry_flag <= c;
        while (!done) begin
            @(negedge clk);
            count++;
            if (pc_drive) begin
                done = 1;
                compare("mar_load", 1, 32'(mar_load));
            end else begin
                if (count == 2) check_fetch_data();
                if (bus_drive && !saw_bus) begin
                    saw_bus  = 1;
                    bus_seen = bus_data;
                    bus_rb   = rb_addr;
                end
                if (pc_load) saw_pc_load = 1;
                if (count == 3) flags_exec = flags_load;  // First execute step
                if (count >= 3 && mar_load) mar_exec = 1;
                last_alu     = alu_op;
                last_rb      = rb_addr;
                last_src_a   = alu_src_a;
                last_src_b   = alu_src_b;
                last_strobes = {alu_load, rb_load, rb_drive, ram_load, ram_drive, out_load};
                if (count > 20) give_up($sformatf("next step 0 after %h", word));
            end
        end
        compare("length", exp_len, count - 1);
        compare("bus_drive", 32'(has_bus), 32'(saw_bus));
        if (has_bus) compare("bus_data", exp_bus, bus_seen);
        compare("pc_load", 32'(exp_taken), 32'(saw_pc_load));
        compare("alu_op", 32'(exp_alu), 32'(last_alu));
        compare("rb_addr", 32'(exp_rb), 32'(last_rb));
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_NOT: begin
                compare("alu_src_a", 32'(word[22:19]), 32'(last_src_a));
                compare("alu_src_b", 32'(word[18:15]), 32'(last_src_b));
                compare("alu_load", 1, 32'(last_strobes[5]));
                compare("rb_load", 1, 32'(last_strobes[4]));
            end
            OP_ADDI, OP_SUBI, OP_ANDI, OP_ORI, OP_SLL, OP_SRL: begin
                compare("rb_addr on bus load", 32'(TEMP_REG), 32'(bus_rb));
                compare("alu_src_a", 32'(word[22:19]), 32'(last_src_a));
                compare("alu_src_b", 32'(TEMP_REG), 32'(last_src_b));
                compare("alu_load", 1, 32'(last_strobes[5]));
                compare("rb_load", 1, 32'(last_strobes[4]));
            end
            OP_LW: begin
                compare("mar_load in execute", 1, 32'(mar_exec));
                compare("ram_drive", 1, 32'(last_strobes[1]));
                compare("rb_load", 1, 32'(last_strobes[4]));
            end
            OP_SW: begin
                compare("mar_load in execute", 1, 32'(mar_exec));
                compare("ram_load", 1, 32'(last_strobes[2]));
                compare("rb_drive", 1, 32'(last_strobes[3]));
            end
            OP_JEQ, OP_JNE: compare("flags_load", 1, 32'(flags_exec));
            OP_OUT: begin
                compare("out_load", 1, 32'(last_strobes[0]));
                compare("rb_drive", 1, 32'(last_strobes[3]));
            end
            default: ;
        endcase
    endtask

    // HALT parks in the execute step, only reset brings the fetch back
    task automatic check_halt(input logic [31:0] word);
        @(posedge clk);
        ir_word <= word;
        repeat (20) begin
            @(negedge clk);
            if (pc_drive) begin
                $display("pc_drive seen while halted");
                $display("Test failed");
                $fatal(1);
            end
        end
        @(posedge clk);
        reset <= 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        wait_fetch("step 0 after reset from HALT");
        @(negedge clk);
        check_fetch_data();
    endtask

    initial begin
        int          fd;
        int          n;
        string       line;
        string       bus_txt;
        logic [31:0] word;
        logic [31:0] z;
        logic [31:0] c;
        int          len;
        logic [31:0] exp_bus;
        logic [31:0] taken;
        logic [31:0] alu;
        logic [31:0] rb;
        reset      = 1'b1;
        ir_word    = '0;
        zero_flag  = 1'b0;
        carry_flag = 1'b0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        fd = $fopen("bench/decoder_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/decoder_trace.txt");
            $display("Test failed");
            $fatal(1);
        end

        wait_fetch("first step 0 after reset");
        @(negedge clk);
        check_fetch_data();   // Very first fetch
        wait_fetch("step 0 after first fetch");

        while ($fgets(line, fd)) begin
            if (line.len() < 2 || line.getc(0) == "#") continue;
            n = $sscanf(line, "%h %h %h %d %s %h %h %h",
                        word, z, c, len, bus_txt, taken, alu, rb);
            if (n != 8) begin
                $display("malformed trace line: %s", line);
                $display("Test failed");
                $fatal(1);
            end
            if (len == 0) begin
                check_halt(word);
            end else begin
                exp_bus = '0;
                if (bus_txt != "none") n = $sscanf(bus_txt, "%h", exp_bus);
                run_instruction(word, z[0], c[0], len, bus_txt != "none", exp_bus,
                                taken[0], alu[2:0], rb[3:0]);
            end
        end
        $fclose(fd);

        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: instruction_decoder.f
hdl/ctrl_pkg.sv
hdl/operand_decoder.sv
hdl/control_sequencer.sv
hdl/instruction_decoder.sv
bench/decoder_props.sv
bench/tb_instruction_decoder.sv

// File: Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f instruction_decoder.f \
		--top-module tb_instruction_decoder -o sim_tb

run: build
	./obj_dir/sim_tb | tee sim.log
	grep -q "Test completed successfully" sim.log

lint:
	verilator --lint-only --timing -f instruction_decoder.f \
		--top-module tb_instruction_decoder

clean:
	rm -rf obj_dir sim.log

// File: bench/decoder_trace.txt
# word zero carry length bus(hex or none) taken alu_op rb_addr
# length 0 marks HALT, which must hold until reset
09A28000 0 0 3 none 0 0 3
11080000 0 0 3 none 0 1 2
1B800000 0 0 3 none 0 2 7
24000000 0 0 3 none 0 3 8
2F800000 0 0 3 none 0 4 f
C4800000 0 0 3 none 0 7 9
49012345 0 0 4 00012345 0 0 2
9A07FFFF 0 0 4 0007FFFF 0 1 4
528000FF 0 0 4 000000FF 0 2 5
5B000F00 0 0 4 00000F00 0 3 6
35000003 0 0 4 00000003 0 5 a
3D80001F 0 0 4 0000001F 0 6 b
61A00010 0 0 5 00000010 0 0 3
6B100020 0 0 5 00000020 0 0 6
46000000 0 0 3 none 0 0 c
70000400 0 0 4 00000400 1 0 0
A2400001 0 0 3 FFC00001 0 0 4
AA400001 0 0 3 00400001 0 0 4
78900100 1 0 4 00000100 1 0 0
78900100 0 1 4 none 0 0 0
80900100 0 0 4 00000100 1 0 0
80900100 1 1 4 none 0 0 0
88123456 0 1 3 00123456 1 0 0
88123456 1 0 3 none 0 0 0
90000ABC 1 0 3 00000ABC 1 0 0
90000ABC 0 1 3 none 0 0 0
B7FFFFFF 1 1 3 07FFFFFF 1 0 0
B7FFFFFF 0 1 3 none 0 0 0
B8000042 0 0 3 00000042 1 0 0
B8000042 1 0 3 none 0 0 0
00000000 0 0 8 none 0 0 0
C8000000 0 0 8 none 0 0 0
F8000000 0 0 0 none 0 0 0
